// File: verilog/ecc_config.svh
`ifndef ECC_CONFIG_SVH
`define ECC_CONFIG_SVH

// datapath, smaller codes are zero padded up to this
`define CODE_W 32
`define HAM_ROWS 5  // most Hamming parity rows of any mode

`define INFO_W_M0 4
`define INFO_W_M1 11
`define INFO_W_M2 26

// parity counts include the overall bit
`define PAR_W_M0 4
`define PAR_W_M1 5
`define PAR_W_M2 6

// lower H rows, row j gives parity bit j
`define H_M0_ROW0 32'h0000_00b1
`define H_M0_ROW1 32'h0000_00d2
`define H_M0_ROW2 32'h0000_00e4

`define H_M1_ROW0 32'h0000_ab61
`define H_M1_ROW1 32'h0000_cda2
`define H_M1_ROW2 32'h0000_f1c4
`define H_M1_ROW3 32'h0000_fe08

`define H_M2_ROW0 32'haaab_56c1
`define H_M2_ROW1 32'hcccd_9b42
`define H_M2_ROW2 32'hf0f1_e384
`define H_M2_ROW3 32'hff01_fc08
`define H_M2_ROW4 32'hfffe_0010

`endif

// File: verilog/ecc_pkg.sv
`default_nettype none

`include "ecc_config.svh"

package ecc_pkg;

    typedef enum logic [1:0] {
        mode_8  = 2'd0,
        mode_16 = 2'd1,
        mode_32 = 2'd2  // 3 is illegal
    } work_mode_t;

    typedef enum logic [1:0] {
        op_encode  = 2'd0,
        op_decode  = 2'd1,
        op_channel = 2'd2
    } opcode_t;

    typedef enum logic [1:0] {
        st_idle,
        st_enc,
        st_dec,
        st_done
    } ctrl_state_t;

    function automatic int unsigned info_w(work_mode_t m);
        case (m)
            mode_8:  return `INFO_W_M0;
            mode_16: return `INFO_W_M1;
            mode_32: return `INFO_W_M2;
            default: return 0;
        endcase
    endfunction

    function automatic int unsigned par_w(work_mode_t m);
        case (m)
            mode_8:  return `PAR_W_M0;
            mode_16: return `PAR_W_M1;
            mode_32: return `PAR_W_M2;
            default: return 0;
        endcase
    endfunction

    // n ones, right aligned
    function automatic logic [`CODE_W-1:0] low_mask(int unsigned n);
        if (n >= `CODE_W) begin
            return '1;
        end
        return ({{(`CODE_W-1){1'b0}}, 1'b1} << n) - 1'b1;
    endfunction

    // H row j of the given mode, zero where the mode has no such row
    function automatic logic [`CODE_W-1:0] h_mask(work_mode_t m, int unsigned j);
        logic [`CODE_W-1:0] rows [`HAM_ROWS];
        rows = '{default: '0};
        case (m)
            mode_8: begin
                rows[0] = `H_M0_ROW0;
                rows[1] = `H_M0_ROW1;
                rows[2] = `H_M0_ROW2;
            end
            mode_16: begin
                rows[0] = `H_M1_ROW0;
                rows[1] = `H_M1_ROW1;
                rows[2] = `H_M1_ROW2;
                rows[3] = `H_M1_ROW3;
            end
            mode_32: begin
                rows[0] = `H_M2_ROW0;
                rows[1] = `H_M2_ROW1;
                rows[2] = `H_M2_ROW2;
                rows[3] = `H_M2_ROW3;
                rows[4] = `H_M2_ROW4;
            end
            default: ;
        endcase
        return (j < `HAM_ROWS) ? rows[j] : '0;
    endfunction

endpackage

`default_nettype wire

// File: verilog/ecc_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

// one word handed from block to block, no ready
interface ecc_stage_if import ecc_pkg::*; ();

    logic [`CODE_W-1:0] word;
    work_mode_t         mode;
    logic               valid;    // single cycle strobe
    logic [1:0]         num_err;  // only the decoder fills this in

    modport src (
        output word,
        output mode,
        output valid,
        output num_err
    );

    modport dst (
        input word,
        input mode,
        input valid,
        input num_err
    );

endinterface

`default_nettype wire

// File: verilog/enc_parity_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module enc_parity_gen import ecc_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    ecc_stage_if.dst in_if,
    ecc_stage_if.src out_if
);

    logic [`CODE_W-1:0]   info_pos;  // info moved up, parity slots still zero
    logic [`HAM_ROWS-1:0] par;

    always_comb begin
        info_pos = (in_if.word & low_mask(info_w(in_if.mode))) << par_w(in_if.mode);
        // unused rows give a zero mask, so their bits stay zero
        for (int j = 0; j < `HAM_ROWS; j++) begin
            par[j] = ^(info_pos & h_mask(in_if.mode, j));
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_if.valid <= 1'b0;
        end else begin
            out_if.valid <= in_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_if.valid) begin
            out_if.word <= info_pos | {{(`CODE_W-`HAM_ROWS){1'b0}}, par};
            out_if.mode <= in_if.mode;
        end
    end

    assign out_if.num_err = 2'b00;

    a_mode_legal: assert property (
        @(posedge clk) disable iff (!rst)
        in_if.valid |-> in_if.mode inside {mode_8, mode_16, mode_32}
    ) else $error("encoder launched with illegal mode %0d", in_if.mode);

endmodule

`default_nettype wire

// File: verilog/enc_overall_parity.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module enc_overall_parity import ecc_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    ecc_stage_if.dst in_if,
    ecc_stage_if.src out_if
);

    logic               ovr_par;  // all ones row times the word
    logic [`CODE_W-1:0] cw;

    assign ovr_par = ^in_if.word;

    always_comb begin
        case (in_if.mode)
            mode_8: cw = {{(`CODE_W-`INFO_W_M0-`PAR_W_M0){1'b0}},
                          in_if.word[`INFO_W_M0+`PAR_W_M0-1:`PAR_W_M0],
                          ovr_par,
                          in_if.word[`PAR_W_M0-2:0]};
            mode_16: cw = {{(`CODE_W-`INFO_W_M1-`PAR_W_M1){1'b0}},
                           in_if.word[`INFO_W_M1+`PAR_W_M1-1:`PAR_W_M1],
                           ovr_par,
                           in_if.word[`PAR_W_M1-2:0]};
            mode_32: cw = {in_if.word[`INFO_W_M2+`PAR_W_M2-1:`PAR_W_M2],  // full width, no pad
                           ovr_par,
                           in_if.word[`PAR_W_M2-2:0]};
            default: cw = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_if.valid <= 1'b0;
        end else begin
            out_if.valid <= in_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_if.valid) begin
            out_if.word <= cw;
            out_if.mode <= in_if.mode;
        end
    end

    assign out_if.num_err = 2'b00;

    // odd only if stage 1 left bits set outside the layout
    a_cw_even: assert property (
        @(posedge clk) disable iff (!rst)
        out_if.valid |-> (^out_if.word) == 1'b0
    ) else $error("stage 2 codeword has odd parity");

endmodule

`default_nettype wire

// File: verilog/dec_syndrome_correct.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module dec_syndrome_correct import ecc_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    ecc_stage_if.dst in_if,
    ecc_stage_if.src out_if
);

    logic [`CODE_W-1:0]   rows [`HAM_ROWS];
    logic [`CODE_W-1:0]   rx_word;     // pad bits cleared
    logic [`CODE_W-1:0]   flip;
    logic [`CODE_W-1:0]   fixed_word;
    logic [`CODE_W-1:0]   info_out;
    logic [`HAM_ROWS-1:0] syndrome;
    logic [`HAM_ROWS-1:0] h_col;
    logic                 ovr_odd;
    logic [1:0]           err_cnt;

    always_comb begin
        rx_word = in_if.word & low_mask(info_w(in_if.mode) + par_w(in_if.mode));
        for (int j = 0; j < `HAM_ROWS; j++) begin
            rows[j]     = h_mask(in_if.mode, j);
            syndrome[j] = ^(rx_word & rows[j]);
        end
        ovr_odd = ^rx_word;

        // flip the bit whose H column equals the syndrome
        // zero syndrome with odd parity means the overall bit, outside the info
        for (int k = 0; k < `CODE_W; k++) begin
            for (int j = 0; j < `HAM_ROWS; j++) begin
                h_col[j] = rows[j][k];
            end
            flip[k] = ovr_odd && (syndrome != '0) && (h_col == syndrome);
        end
        fixed_word = rx_word ^ flip;

        if (ovr_odd) begin
            err_cnt = 2'd1;
        end else if (syndrome != '0) begin
            err_cnt = 2'd2;  // detected, not corrected
        end else begin
            err_cnt = 2'd0;
        end

        info_out = (fixed_word >> par_w(in_if.mode)) & low_mask(info_w(in_if.mode));
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_if.valid <= 1'b0;
        end else begin
            out_if.valid <= in_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_if.valid) begin
            out_if.word    <= info_out;  // right aligned
            out_if.mode    <= in_if.mode;
            out_if.num_err <= err_cnt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ecc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_ctrl import ecc_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire  [1:0]         opcode,
    input  wire  [1:0]         work_mod,
    input  wire  [`CODE_W-1:0] data_in,
    input  wire  [`CODE_W-1:0] noise,
    output logic [`CODE_W-1:0] data_out,
    output logic [1:0]         num_of_errors,
    output logic               done,
    output logic               busy,
    ecc_stage_if.src           enc_out,
    ecc_stage_if.dst           enc_in,
    ecc_stage_if.src           dec_out,
    ecc_stage_if.dst           dec_in
);

    ctrl_state_t        state;
    opcode_t            op_in;
    opcode_t            op_r;
    work_mode_t         mode_in;
    logic [`CODE_W-1:0] noise_r;
    logic               mode_ok;
    logic               op_ok;
    logic               launch;

    assign op_in   = opcode_t'(opcode);
    assign mode_in = work_mode_t'(work_mod);
    assign mode_ok = mode_in inside {mode_8, mode_16, mode_32};
    assign op_ok   = op_in inside {op_encode, op_decode, op_channel};
    assign launch  = (state == st_idle) && start;

    assign done = (state == st_done);  // state holds st_done for one cycle only
    assign busy = (state == st_enc) || (state == st_dec);

    assign enc_out.num_err = 2'b00;
    assign dec_out.num_err = 2'b00;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state         <= st_idle;
            op_r          <= op_encode;
            enc_out.valid <= 1'b0;
            dec_out.valid <= 1'b0;
            data_out      <= '0;
            num_of_errors <= 2'b00;
        end else begin
            enc_out.valid <= 1'b0;
            dec_out.valid <= 1'b0;
            case (state)
                st_idle: if (start) begin
                    op_r <= op_in;
                    if (!mode_ok || !op_ok) begin
                        // bad request, answer at once with zero data
                        data_out      <= '0;
                        num_of_errors <= 2'b00;
                        state         <= st_done;
                    end else if (op_in == op_decode) begin
                        dec_out.valid <= 1'b1;
                        state         <= st_dec;
                    end else begin
                        enc_out.valid <= 1'b1;
                        state         <= st_enc;
                    end
                end
                st_enc: if (enc_in.valid) begin
                    if (op_r == op_channel) begin
                        dec_out.valid <= 1'b1;  // noisy codeword on to the decoder
                        state         <= st_dec;
                    end else begin
                        data_out      <= enc_in.word;
                        num_of_errors <= 2'b00;
                        state         <= st_done;
                    end
                end
                st_dec: if (dec_in.valid) begin
                    data_out      <= dec_in.word;
                    num_of_errors <= dec_in.num_err;
                    state         <= st_done;
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // operand and forwarded words
    always_ff @(posedge clk) begin
        if (launch) begin
            enc_out.word <= data_in;
            enc_out.mode <= mode_in;
            dec_out.word <= data_in;
            dec_out.mode <= mode_in;
            noise_r      <= noise;
        end else if (state == st_enc && enc_in.valid) begin
            dec_out.word <= enc_in.word ^ noise_r;
            dec_out.mode <= enc_in.mode;  // mode travels with the codeword
        end
    end

    a_result_awaited: assert property (
        @(posedge clk) disable iff (!rst)
        (enc_in.valid || dec_in.valid) |-> busy
    ) else $error("block result arrived while not busy");

    a_start_mode: assert property (
        @(posedge clk) disable iff (!rst)
        launch |-> mode_ok
    ) else $warning("start with illegal mode %0d, returning zero data", work_mod);

endmodule

`default_nettype wire

// File: verilog/ecc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_top import ecc_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire  [1:0]         opcode,
    input  wire  [1:0]         work_mod,
    input  wire  [`CODE_W-1:0] data_in,
    input  wire  [`CODE_W-1:0] noise,
    output logic [`CODE_W-1:0] data_out,
    output logic [1:0]         num_of_errors,
    output logic               done,
    output logic               busy
);

    ecc_stage_if to_enc   ();  // ctrl to stage 1
    ecc_stage_if mid_enc  ();  // stage 1 to stage 2
    ecc_stage_if from_enc ();
    ecc_stage_if to_dec   ();
    ecc_stage_if from_dec ();

    ecc_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .opcode        (opcode),
        .work_mod      (work_mod),
        .data_in       (data_in),
        .noise         (noise),
        .data_out      (data_out),
        .num_of_errors (num_of_errors),
        .done          (done),
        .busy          (busy),
        .enc_out       (to_enc.src),
        .enc_in        (from_enc.dst),
        .dec_out       (to_dec.src),
        .dec_in        (from_dec.dst)
    );

    enc_parity_gen u_enc_s1 (
        .clk    (clk),
        .rst    (rst),
        .in_if  (to_enc.dst),
        .out_if (mid_enc.src)
    );

    enc_overall_parity u_enc_s2 (
        .clk    (clk),
        .rst    (rst),
        .in_if  (mid_enc.dst),
        .out_if (from_enc.src)
    );

    dec_syndrome_correct u_dec (
        .clk    (clk),
        .rst    (rst),
        .in_if  (to_dec.dst),
        .out_if (from_dec.src)
    );

endmodule

`default_nettype wire

// File: tb/ecc_ref.svh
`ifndef ECC_REF_SVH
`define ECC_REF_SVH

// mode numbers: 0 is the 8 bit code, 1 the 16 bit, 2 the 32 bit
function automatic int info_len(int m);
    return (m == 0) ? `INFO_W_M0 : (m == 1) ? `INFO_W_M1 : `INFO_W_M2;
endfunction

function automatic int par_len(int m);
    return (m == 0) ? `PAR_W_M0 : (m == 1) ? `PAR_W_M1 : `PAR_W_M2;
endfunction

function automatic logic [31:0] h_row(int m, int j);
    logic [5*32-1:0] tbl;  // rows packed 4 down to 0
    case (m)
        0: tbl = {64'h0, `H_M0_ROW2, `H_M0_ROW1, `H_M0_ROW0};
        1: tbl = {32'h0, `H_M1_ROW3, `H_M1_ROW2, `H_M1_ROW1, `H_M1_ROW0};
        default: tbl = {`H_M2_ROW4, `H_M2_ROW3, `H_M2_ROW2, `H_M2_ROW1, `H_M2_ROW0};
    endcase
    return tbl[j*32 +: 32];
endfunction

function automatic logic [31:0] encode_word(int m, logic [31:0] info);
    logic [31:0] base;
    logic [31:0] cw;
    int p;
    p = par_len(m);
    base = (info & ((32'd1 << info_len(m)) - 32'd1)) << p;
    cw = base;
    for (int j = 0; j < p - 1; j++) begin
        cw[j] = ^(base & h_row(m, j));
    end
    cw[p-1] = ^cw;  // overall bit makes the whole word even
    return cw;
endfunction

function automatic bit is_codeword(int m, logic [31:0] w);
    return encode_word(m, w >> par_len(m)) == w;
endfunction

// brute force, try every single flip instead of a syndrome lookup
function automatic void decode_word(input int m, input logic [31:0] w,
                                    output logic [31:0] info, output logic [1:0] nerr);
    int n;
    n = info_len(m) + par_len(m);
    info = w >> par_len(m);
    nerr = 2'd2;
    if (is_codeword(m, w)) begin
        nerr = 2'd0;
    end else begin
        for (int k = 0; k < n; k++) begin
            if (is_codeword(m, w ^ (32'd1 << k))) begin
                info = (w ^ (32'd1 << k)) >> par_len(m);
                nerr = 2'd1;
            end
        end
    end
endfunction

function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // galois, taps 16 14 13 11
endfunction

`endif

// File: tb/ecc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_tb import ecc_pkg::*; ();

    `include "ecc_ref.svh"

    localparam int RST_CYCLES = 8;
    localparam int OP_LIMIT   = 10;  // done wait per operation
    localparam int N_OPS      = 6 + 6 + 56 + 6 + 4;
    localparam int OP_CYCLES  = 8;   // longest op, start to idle again
    localparam int MAX_CYCLES = RST_CYCLES + N_OPS * OP_CYCLES + 40;

    logic        clk;
    logic        rst;
    logic        start;
    logic [1:0]  opcode;
    logic [1:0]  work_mod;
    logic [31:0] data_in;
    logic [31:0] noise;
    logic [31:0] data_out;
    logic [1:0]  num_of_errors;
    logic        done;
    logic        busy;

    logic [15:0] lfsr;
    int          cycles;
    int          test_errs;
    int          n_pass;
    int          n_fail;

    ecc_top DUT (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .opcode        (opcode),
        .work_mod      (work_mod),
        .data_in       (data_in),
        .noise         (noise),
        .data_out      (data_out),
        .num_of_errors (num_of_errors),
        .done          (done),
        .busy          (busy)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, tests did not finish", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    task automatic note_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
        $display("FAIL %s: got %h expected %h", sig, got, exp);
        test_errs++;
    endtask

    task automatic finish_test(string name);
        if (test_errs == 0) begin
            $display("%s ok", name);
            n_pass++;
        end else begin
            $display("%s failed with %0d errors", name, test_errs);
            n_fail++;
        end
        test_errs = 0;
    endtask

    // lat counts edges from the one that samples start to the one that raises done
    task automatic run_op(input int m, input logic [1:0] op, input logic [31:0] din,
                          input logic [31:0] nz, output int lat);
        bit seen;
        @(posedge clk);
        #2;
        start    = 1'b1;
        opcode   = op;
        work_mod = 2'(m);
        data_in  = din;
        noise    = nz;
        @(posedge clk);
        #2;
        start = 1'b0;
        lat   = 0;
        seen  = 1'b0;
        while (!seen && lat <= OP_LIMIT) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                lat++;
            end
        end
        if (!seen) begin
            $display("no done within %0d cycles of start", OP_LIMIT);
            test_errs++;
        end
    endtask

    task automatic reset_and_busy();
        logic [31:0] info_a;
        logic [31:0] exp;
        int          dones;
        if (data_out !== '0) note_mismatch("data_out", data_out, 32'h0);
        if (num_of_errors !== 2'd0) note_mismatch("num_of_errors", 32'(num_of_errors), 32'h0);
        if (done !== 1'b0) note_mismatch("done", 32'(done), 32'h0);
        if (busy !== 1'b0) note_mismatch("busy", 32'(busy), 32'h0);
        info_a = random_bits(`INFO_W_M1);
        exp    = encode_word(1, info_a);
        @(posedge clk);
        #2;
        start    = 1'b1;
        opcode   = op_encode;
        work_mod = 2'd1;
        data_in  = info_a;
        @(posedge clk);
        #2;
        data_in = info_a ^ 32'h7ff;  // second request, must be dropped
        opcode  = op_channel;
        @(negedge clk);
        if (busy !== 1'b1) note_mismatch("busy", 32'(busy), 32'h1);
        @(posedge clk);
        #2;
        start = 1'b0;
        dones = 0;
        repeat (10) begin
            @(negedge clk);
            if (done) begin
                dones++;
                if (data_out !== exp) note_mismatch("data_out", data_out, exp);
            end
        end
        if (dones != 1) begin
            $display("expected one done pulse after a start while busy, saw %0d", dones);
            test_errs++;
        end
        finish_test("reset values and start while busy");
    endtask

    task automatic encode_modes();
        logic [31:0] info;
        int          lat;
        for (int m = 0; m < 3; m++) begin
            repeat (2) begin
                info = random_bits(info_len(m));
                run_op(m, op_encode, info, 32'h0, lat);
                if (lat != 3) note_mismatch("done latency", 32'(lat), 32'd3);
                if (data_out !== encode_word(m, info))
                    note_mismatch("data_out", data_out, encode_word(m, info));
                if (num_of_errors !== 2'd0)
                    note_mismatch("num_of_errors", 32'(num_of_errors), 32'h0);
            end
        end
        finish_test("encode in all modes");
    endtask

    task automatic clean_decode();
        logic [31:0] info;
        int          lat;
        for (int m = 0; m < 3; m++) begin
            repeat (2) begin
                info = random_bits(info_len(m));
                run_op(m, op_decode, encode_word(m, info), 32'h0, lat);
                if (lat != 2) note_mismatch("done latency", 32'(lat), 32'd2);
                if (data_out !== info) note_mismatch("data_out", data_out, info);
                if (num_of_errors !== 2'd0)
                    note_mismatch("num_of_errors", 32'(num_of_errors), 32'h0);
            end
        end
        finish_test("clean decode");
    endtask

    // noisy decode through the channel, expectation from the brute force decoder
    task automatic channel_check(int m, logic [31:0] info, logic [31:0] nz, bit check_data);
        logic [31:0] exp_info;
        logic [1:0]  exp_n;
        int          lat;
        decode_word(m, encode_word(m, info) ^ nz, exp_info, exp_n);
        run_op(m, op_channel, info, nz, lat);
        if (lat != 5) note_mismatch("done latency", 32'(lat), 32'd5);
        if (check_data && data_out !== exp_info) note_mismatch("data_out", data_out, exp_info);
        if (num_of_errors !== exp_n)
            note_mismatch("num_of_errors", 32'(num_of_errors), 32'(exp_n));
    endtask

    task automatic single_error_channel();
        logic [31:0] info;
        for (int m = 0; m < 3; m++) begin
            info = random_bits(info_len(m));
            for (int k = 0; k < info_len(m) + par_len(m); k++) begin
                channel_check(m, info, 32'd1 << k, 1'b1);
                if (num_of_errors !== 2'd1) note_mismatch("num_of_errors", 32'(num_of_errors), 32'h1);
            end
        end
        finish_test("single error channel");
    endtask

    task automatic double_error_channel();
        int a;
        int b;
        int n;
        for (int m = 0; m < 3; m++) begin
            n = info_len(m) + par_len(m);
            repeat (2) begin
                a = int'(random_bits(5)) % n;
                b = (a + 1 + int'(random_bits(5)) % (n - 1)) % n;  // never equal to a
                channel_check(m, random_bits(info_len(m)), (32'd1 << a) | (32'd1 << b), 1'b0);
                if (num_of_errors !== 2'd2) note_mismatch("num_of_errors", 32'(num_of_errors), 32'h2);
            end
        end
        finish_test("double error detection");
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        start     = 1'b0;
        opcode    = 2'd0;
        work_mod  = 2'd0;
        data_in   = '0;
        noise     = '0;
        lfsr      = 16'd76;
        cycles    = 0;
        test_errs = 0;
        n_pass    = 0;
        n_fail    = 0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b1;
        reset_and_busy();
        encode_modes();
        clean_decode();
        single_error_channel();
        double_error_channel();
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
+incdir+tb
verilog/ecc_pkg.sv
verilog/ecc_stage_if.sv
verilog/enc_parity_gen.sv
verilog/enc_overall_parity.sv
verilog/dec_syndrome_correct.sv
verilog/ecc_ctrl.sv
verilog/ecc_top.sv
tb/ecc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ECC codec testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module ecc_tb -Mdir obj_dir -o ecc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ecc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
